// File: mem_unit_pkg.sv
// --------------------
// Shared widths, types, instruction encoding, cache command and size codes
// Memory map of the cached store and the I/O window
// --------------------
package mem_unit_pkg;

    // Widths --------------------
    localparam int ADDR_W = 40;                    // Physical address seen by the cache
    localparam int XLEN   = 64;
    localparam int REG_W  = 5;
    localparam int TAG_W  = 8;
    localparam int PMU_W  = 16;                    // Event counter width

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [XLEN-1:0]   bus64_t;
    typedef logic [REG_W-1:0]  reg_addr_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [PMU_W-1:0]  pmu_cnt_t;
    typedef logic [4:0]        dcache_cmd_t;
    typedef logic [3:0]        op_type_t;      // [1:0] size, [2] unsigned load
    typedef logic [1:0]        mem_class_t;

    // Memory instructions handled by this stage
    typedef enum logic [4:0] {
        NOP,
        LB, LBU, LH, LHU, LW, LWU, LD,
        SB, SH, SW, SD,
        AMO_SWAPD, AMO_ADDD, AMO_XORD, AMO_ANDD, AMO_ORD,
        AMO_MIND, AMO_MAXD, AMO_MINDU, AMO_MAXDU
    } instr_t;

    // Cache commands --------------------
    localparam dcache_cmd_t CMD_LOAD  = 5'd0;
    localparam dcache_cmd_t CMD_STORE = 5'd1;
    localparam dcache_cmd_t CMD_SWAP  = 5'd4;
    localparam dcache_cmd_t CMD_ADD   = 5'd8;
    localparam dcache_cmd_t CMD_XOR   = 5'd9;
    localparam dcache_cmd_t CMD_OR    = 5'd10;
    localparam dcache_cmd_t CMD_AND   = 5'd11;
    localparam dcache_cmd_t CMD_MIN   = 5'd12;
    localparam dcache_cmd_t CMD_MAX   = 5'd13;
    localparam dcache_cmd_t CMD_MINU  = 5'd14;
    localparam dcache_cmd_t CMD_MAXU  = 5'd15;

    // Access granularity
    localparam logic [1:0] SZ_B = 2'b00;
    localparam logic [1:0] SZ_H = 2'b01;
    localparam logic [1:0] SZ_W = 2'b10;
    localparam logic [1:0] SZ_D = 2'b11;
    localparam int         OPT_UNS_BIT = 2;        // Zero extension on loads

    localparam op_type_t OPT_B  = {2'b00, SZ_B};
    localparam op_type_t OPT_H  = {2'b00, SZ_H};
    localparam op_type_t OPT_W  = {2'b00, SZ_W};
    localparam op_type_t OPT_D  = {2'b00, SZ_D};
    localparam op_type_t OPT_BU = {2'b01, SZ_B};
    localparam op_type_t OPT_HU = {2'b01, SZ_H};
    localparam op_type_t OPT_WU = {2'b01, SZ_W};

    // Operation classes
    localparam mem_class_t CLS_NOP   = 2'b00;
    localparam mem_class_t CLS_LOAD  = 2'b01;
    localparam mem_class_t CLS_STORE = 2'b10;
    localparam mem_class_t CLS_AMO   = 2'b11;

    // Memory map --------------------
    localparam addr_t MEM_BASE_ADDR = 40'h00_8000_0000;   // Start of cached region
    localparam int    MEM_WORDS     = 256;                // 2 KiB of doublewords
    localparam int    MEM_IDX_W     = $clog2(MEM_WORDS);
    localparam addr_t MEM_END_ADDR  = MEM_BASE_ADDR + addr_t'(MEM_WORDS * 8);
    localparam addr_t IO_TOP_ADDR   = 40'h00_8000_0000;   // Exclusive top of I/O window

endpackage

// File: dcache_bus_if.sv
// --------------------
// Cache request and response channels, core and cache modports
// --------------------
`timescale 1ns/1ns

interface dcache_bus_if import mem_unit_pkg::*; ();

    // Request channel
    logic        req_valid;
    logic        req_ready;
    dcache_cmd_t req_cmd;
    addr_t       req_addr;
    op_type_t    req_op_type;
    bus64_t      req_data;                     // Store data or AMO operand
    tag_t        req_tag;
    logic        req_kill;                     // Drop in flight, no response

    // Response channel, no back-pressure
    logic        resp_valid;
    bus64_t      resp_data;
    tag_t        resp_tag;
    logic        resp_xcpt_ma;                 // Misaligned
    logic        resp_xcpt_pf;                 // Out of cached range

    // Pipeline side
    modport core (
        output req_valid, req_cmd, req_addr, req_op_type, req_data, req_tag, req_kill,
        input  req_ready,
        input  resp_valid, resp_data, resp_tag, resp_xcpt_ma, resp_xcpt_pf
    );

    // Data cache side
    modport cache (
        input  req_valid, req_cmd, req_addr, req_op_type, req_data, req_tag, req_kill,
        output req_ready,
        output resp_valid, resp_data, resp_tag, resp_xcpt_ma, resp_xcpt_pf
    );

endinterface

// File: dcache_interface.sv
// --------------------
// Memory instruction decode, address generation and cache tag
// I/O window flag, response forwarding and PMU event flags
// --------------------
`timescale 1ns/1ns

module dcache_interface import mem_unit_pkg::*; (
    input  logic            req_valid_i,
    input  instr_t          req_instr_i,
    input  bus64_t          req_rs1_i,
    input  bus64_t          req_imm_i,
    input  bus64_t          req_rs2_i,
    input  reg_addr_t       req_rd_i,
    input  logic            req_kill_i,
    input  addr_t           io_base_addr_i,    // Bottom of I/O window

    dcache_bus_if.core      dbus,

    output logic            resp_valid_o,
    output bus64_t          resp_data_o,
    output reg_addr_t       resp_rd_o,
    output logic            resp_xcpt_ma_o,
    output logic            resp_xcpt_pf_o,
    output logic            io_space_o,
    output logic            is_load_o,         // PMU events, qualified by valid
    output logic            is_store_o,
    output logic            is_amo_o
);

    mem_class_t  mem_cls;
    dcache_cmd_t req_cmd;
    op_type_t    req_op_type;
    bus64_t      addr_64;                      // Full-width effective address
    addr_t       req_addr;

    // Decode --------------------

    // Operation class
    always_comb begin
        case (req_instr_i)
            LB, LBU, LH, LHU, LW, LWU, LD: mem_cls = CLS_LOAD;
            SB, SH, SW, SD:                mem_cls = CLS_STORE;
            AMO_SWAPD, AMO_ADDD, AMO_XORD, AMO_ANDD, AMO_ORD,
            AMO_MIND, AMO_MAXD, AMO_MINDU, AMO_MAXDU: mem_cls = CLS_AMO;
            default:                       mem_cls = CLS_NOP;
        endcase
    end

    // Cache command
    always_comb begin
        case (req_instr_i)
            SB, SH, SW, SD: req_cmd = CMD_STORE;
            AMO_SWAPD:      req_cmd = CMD_SWAP;
            AMO_ADDD:       req_cmd = CMD_ADD;
            AMO_XORD:       req_cmd = CMD_XOR;
            AMO_ANDD:       req_cmd = CMD_AND;
            AMO_ORD:        req_cmd = CMD_OR;
            AMO_MIND:       req_cmd = CMD_MIN;
            AMO_MAXD:       req_cmd = CMD_MAX;
            AMO_MINDU:      req_cmd = CMD_MINU;
            AMO_MAXDU:      req_cmd = CMD_MAXU;
            default:        req_cmd = CMD_LOAD;   // Loads and NOP
        endcase
    end

    // Access size, atomics are always doubleword
    always_comb begin
        case (req_instr_i)
            LB, SB:  req_op_type = OPT_B;
            LBU:     req_op_type = OPT_BU;
            LH, SH:  req_op_type = OPT_H;
            LHU:     req_op_type = OPT_HU;
            LW, SW:  req_op_type = OPT_W;
            LWU:     req_op_type = OPT_WU;
            default: req_op_type = OPT_D;
        endcase
    end

    // Address --------------------

    // AMOs use rs1 directly, the rest add the immediate
    assign addr_64  = (mem_cls == CLS_AMO) ? req_rs1_i : req_rs1_i + req_imm_i;
    assign req_addr = addr_64[ADDR_W-1:0];

    // Window below the cached region
    assign io_space_o = (req_addr >= io_base_addr_i) && (req_addr < IO_TOP_ADDR);

    // Request to cache --------------------
    assign dbus.req_valid   = req_valid_i && (mem_cls != CLS_NOP);   // NOP never reaches cache
    assign dbus.req_cmd     = req_cmd;
    assign dbus.req_addr    = req_addr;
    assign dbus.req_op_type = req_op_type;
    assign dbus.req_data    = req_rs2_i;
    assign dbus.req_tag     = {2'b00, req_rd_i, 1'b0};            // rd sits in bits 5..1
    assign dbus.req_kill    = req_kill_i;

    // Response to pipeline --------------------
    assign resp_valid_o   = dbus.resp_valid;
    assign resp_data_o    = dbus.resp_data;
    assign resp_rd_o      = dbus.resp_tag[5:1];
    assign resp_xcpt_ma_o = dbus.resp_xcpt_ma;
    assign resp_xcpt_pf_o = dbus.resp_xcpt_pf;

    // PMU event flags
    assign is_load_o  = req_valid_i && (mem_cls == CLS_LOAD);
    assign is_store_o = req_valid_i && (mem_cls == CLS_STORE);
    assign is_amo_o   = req_valid_i && (mem_cls == CLS_AMO);

endmodule

// File: dcache_ram.sv
// --------------------
// Blocking 2 KiB data cache store with AMO read-modify-write
// --------------------
`timescale 1ns/1ns

module dcache_ram import mem_unit_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    dcache_bus_if.cache dbus
);

    typedef enum logic {ST_IDLE, ST_AMO_WRITE} state_t;

    state_t                 state_q;
    bus64_t                 mem [MEM_WORDS];
    logic                   accept;
    logic                   is_load;
    logic                   is_store;
    logic                   is_amo;
    logic                   xcpt_ma;
    logic                   xcpt_pf;
    logic                   fault;
    logic [1:0]             size;
    logic [2:0]             boff;             // Byte lane in the doubleword
    logic [MEM_IDX_W-1:0]   word_idx;
    bus64_t                 rd_word;
    bus64_t                 lane;             // Addressed lane at bit 0
    bus64_t                 load_data;
    logic [7:0]             byte_mask;
    bus64_t                 bit_mask;
    bus64_t                 st_data;          // Store data replicated over lanes
    logic                   mem_we;
    logic [MEM_IDX_W-1:0]   mem_widx;
    bus64_t                 mem_wdata;
    // AMO state kept across the two cycles
    logic [MEM_IDX_W-1:0]   amo_idx_q;
    dcache_cmd_t            amo_cmd_q;
    bus64_t                 amo_old_q;
    bus64_t                 amo_src_q;

    function automatic bus64_t amo_alu(dcache_cmd_t cmd, bus64_t a, bus64_t b);
        case (cmd)
            CMD_ADD:  return a + b;
            CMD_XOR:  return a ^ b;
            CMD_OR:   return a | b;
            CMD_AND:  return a & b;
            CMD_MIN:  return ($signed(a) < $signed(b)) ? a : b;
            CMD_MAX:  return ($signed(a) > $signed(b)) ? a : b;
            CMD_MINU: return (a < b) ? a : b;
            CMD_MAXU: return (a > b) ? a : b;
            default:  return b;                 // Swap
        endcase
    endfunction

    // Request decode --------------------
    assign dbus.req_ready = (state_q == ST_IDLE);
    assign accept   = dbus.req_valid && dbus.req_ready && !dbus.req_kill;
    assign is_load  = (dbus.req_cmd == CMD_LOAD);
    assign is_store = (dbus.req_cmd == CMD_STORE);
    assign is_amo   = !is_load && !is_store;
    assign size     = dbus.req_op_type[1:0];
    assign boff     = dbus.req_addr[2:0];
    assign word_idx = dbus.req_addr[MEM_IDX_W+2:3];

    // Alignment check per size
    assign xcpt_ma = ((size == SZ_H) && boff[0])
                   || ((size == SZ_W) && (boff[1:0] != 2'b00))
                   || ((size == SZ_D) && (boff != 3'b000));
    // Outside the cached region, misalignment wins
    assign xcpt_pf = !xcpt_ma && ((dbus.req_addr < MEM_BASE_ADDR)
                                  || (dbus.req_addr >= MEM_END_ADDR));
    assign fault   = xcpt_ma || xcpt_pf;

    // Load path --------------------
    assign rd_word = mem[word_idx];
    assign lane    = rd_word >> {boff, 3'b000};

    always_comb begin
        logic uns;
        uns = dbus.req_op_type[OPT_UNS_BIT];
        case (size)
            SZ_B:    load_data = {{56{!uns && lane[7]}}, lane[7:0]};
            SZ_H:    load_data = {{48{!uns && lane[15]}}, lane[15:0]};
            SZ_W:    load_data = {{32{!uns && lane[31]}}, lane[31:0]};
            default: load_data = lane;
        endcase
    end

    // Store path, byte mask and lane replication
    always_comb begin
        case (size)
            SZ_B:    byte_mask = 8'h01 << boff;
            SZ_H:    byte_mask = 8'h03 << boff;
            SZ_W:    byte_mask = 8'h0f << boff;
            default: byte_mask = 8'hff;
        endcase
        for (int b = 0; b < 8; b++) begin
            bit_mask[b*8 +: 8] = {8{byte_mask[b]}};
        end
        case (size)
            SZ_B:    st_data = {8{dbus.req_data[7:0]}};
            SZ_H:    st_data = {4{dbus.req_data[15:0]}};
            SZ_W:    st_data = {2{dbus.req_data[31:0]}};
            default: st_data = dbus.req_data;
        endcase
    end

    // Single write port, stores now or AMO result one cycle later
    assign mem_we    = (accept && is_store && !fault) || (state_q == ST_AMO_WRITE);
    assign mem_widx  = (state_q == ST_AMO_WRITE) ? amo_idx_q : word_idx;
    assign mem_wdata = (state_q == ST_AMO_WRITE) ? amo_alu(amo_cmd_q, amo_old_q, amo_src_q)
                                                 : (rd_word & ~bit_mask) | (st_data & bit_mask);

    always_ff @(posedge clk_i) begin
        if (mem_we) begin
            mem[mem_widx] <= mem_wdata;
        end
    end

    // Control --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q         <= ST_IDLE;
            dbus.resp_valid <= 1'b0;
        end else begin
            dbus.resp_valid <= (accept && !(is_amo && !fault)) || (state_q == ST_AMO_WRITE);
            if (state_q == ST_AMO_WRITE) begin
                state_q <= ST_IDLE;
            end else if (accept && is_amo && !fault) begin
                state_q <= ST_AMO_WRITE;        // Hold the cache one more cycle
            end
        end
    end

    // Response payload and AMO latches
    always_ff @(posedge clk_i) begin
        if (accept) begin
            dbus.resp_tag     <= dbus.req_tag;
            dbus.resp_xcpt_ma <= xcpt_ma;
            dbus.resp_xcpt_pf <= xcpt_pf;
            dbus.resp_data    <= (fault || !is_load) ? '0 : load_data;
            amo_idx_q         <= word_idx;
            amo_cmd_q         <= dbus.req_cmd;
            amo_old_q         <= rd_word;       // Old value read in first cycle
            amo_src_q         <= dbus.req_data;
        end else if (state_q == ST_AMO_WRITE) begin
            dbus.resp_data    <= amo_old_q;     // AMO returns old memory value
        end
    end

endmodule

// File: pmu_counters.sv
// --------------------
// Saturating counters of accepted loads, stores and AMOs
// --------------------
`timescale 1ns/1ns

module pmu_counters import mem_unit_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     accept_i,                 // Cache took the request
    input  logic     is_load_i,
    input  logic     is_store_i,
    input  logic     is_amo_i,
    output pmu_cnt_t loads_o,
    output pmu_cnt_t stores_o,
    output pmu_cnt_t amos_o
);

    logic [2:0] event_vec;
    pmu_cnt_t   cnt_q [3];

    // Index 0 loads, 1 stores, 2 AMOs
    assign event_vec = {is_amo_i, is_store_i, is_load_i};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 3; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                // Stick at all ones
                if (accept_i && event_vec[i] && (cnt_q[i] != '1)) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign loads_o  = cnt_q[0];
    assign stores_o = cnt_q[1];
    assign amos_o   = cnt_q[2];

endmodule

// File: mem_unit_top.sv
// --------------------
// Memory-access stage top, cache bus, data cache and PMU
// --------------------
`timescale 1ns/1ns

module mem_unit_top import mem_unit_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,

    // Request from pipeline
    input  logic      req_valid_i,
    input  instr_t    req_instr_i,
    input  bus64_t    req_rs1_i,
    input  bus64_t    req_imm_i,
    input  bus64_t    req_rs2_i,
    input  reg_addr_t req_rd_i,
    input  logic      req_kill_i,
    input  addr_t     io_base_addr_i,

    output logic      req_ready_o,             // Hold request while low

    // Response to pipeline
    output logic      resp_valid_o,
    output bus64_t    resp_data_o,
    output reg_addr_t resp_rd_o,
    output logic      resp_xcpt_ma_o,
    output logic      resp_xcpt_pf_o,
    output logic      io_space_o,

    // PMU
    output pmu_cnt_t  pmu_loads_o,
    output pmu_cnt_t  pmu_stores_o,
    output pmu_cnt_t  pmu_amos_o
);

    logic is_load;
    logic is_store;
    logic is_amo;

    dcache_bus_if dbus ();

    assign req_ready_o = dbus.req_ready;

    dcache_interface u_dcache_interface (
        .req_valid_i    (req_valid_i),
        .req_instr_i    (req_instr_i),
        .req_rs1_i      (req_rs1_i),
        .req_imm_i      (req_imm_i),
        .req_rs2_i      (req_rs2_i),
        .req_rd_i       (req_rd_i),
        .req_kill_i     (req_kill_i),
        .io_base_addr_i (io_base_addr_i),
        .dbus           (dbus.core),
        .resp_valid_o   (resp_valid_o),
        .resp_data_o    (resp_data_o),
        .resp_rd_o      (resp_rd_o),
        .resp_xcpt_ma_o (resp_xcpt_ma_o),
        .resp_xcpt_pf_o (resp_xcpt_pf_o),
        .io_space_o     (io_space_o),
        .is_load_o      (is_load),
        .is_store_o     (is_store),
        .is_amo_o       (is_amo)
    );

    dcache_ram u_dcache_ram (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .dbus    (dbus.cache)
    );

    // Event flags already carry valid
    pmu_counters u_pmu_counters (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .accept_i   (dbus.req_ready && !req_kill_i),
        .is_load_i  (is_load),
        .is_store_i (is_store),
        .is_amo_i   (is_amo),
        .loads_o    (pmu_loads_o),
        .stores_o   (pmu_stores_o),
        .amos_o     (pmu_amos_o)
    );

endmodule

// File: mem_unit_sva.sv
// --------------------
// Concurrent checks on the cache request and response channels
// --------------------
`timescale 1ns/1ns

module mem_unit_sva (
    input logic clk_i,
    input logic reset_i,
    input logic req_ready_i,
    input logic accept_i,
    input logic amo_i,
    input logic fault_i,
    input logic resp_valid_i
);

    logic amo_taken;

    assign amo_taken = accept_i && amo_i && !fault_i;   // AMO that holds the cache

    // Cache blocked during the AMO write cycle
    a_amo_blocks: assert property (@(posedge clk_i) disable iff (reset_i)
        amo_taken |=> !req_ready_i)
        else $error("req_ready high in the cycle after an accepted AMO");

    // Single-cycle accesses answer next cycle, AMOs two cycles after acceptance
    a_resp_follows: assert property (@(posedge clk_i) disable iff (reset_i)
        ((accept_i && !amo_taken) || $past(amo_taken)) |=> resp_valid_i)
        else $error("No response after an accepted request");

    a_no_stray_resp: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(resp_valid_i) |-> ($past(accept_i) || $past(accept_i, 2)))
        else $error("resp_valid rose with no accepted request before it");

endmodule

bind dcache_ram mem_unit_sva u_mem_unit_sva (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_ready_i  (dbus.req_ready),
    .accept_i     (accept),
    .amo_i        (is_amo),
    .fault_i      (fault),
    .resp_valid_i (dbus.resp_valid)
);

// File: tb_mem_unit.sv
// --------------------
// Testbench for the memory-access stage, random stream against a reference model
// --------------------
`timescale 1ns/1ns

module tb_mem_unit import mem_unit_pkg::*; ();

    localparam int          CLK_PERIOD = 8;
    localparam int          N_TXN      = 3000;
    localparam int          MAX_GAP    = 3;              // Idle cycles between requests
    localparam int          AMO_LAT    = 2;
    localparam logic [31:0] SEED       = 32'h8fb3f1b0;
    // Worst case per request is a gap, the AMO hold and the handshake
    localparam int TIMEOUT_NS = (MEM_WORDS + N_TXN) * (MAX_GAP + AMO_LAT + 2) * CLK_PERIOD;

    typedef struct packed {
        bus64_t      data;
        reg_addr_t   rd;
        logic        ma;
        logic        pf;
        logic [31:0] cyc;                                // Cycle the response is due
    } exp_t;

    logic      clk_i = 1'b0;
    logic      reset_i;
    logic      req_valid_i;
    instr_t    req_instr_i;
    bus64_t    req_rs1_i;
    bus64_t    req_imm_i;
    bus64_t    req_rs2_i;
    reg_addr_t req_rd_i;
    logic      req_kill_i;
    addr_t     io_base_addr_i;
    logic      req_ready_o;
    logic      resp_valid_o;
    bus64_t    resp_data_o;
    reg_addr_t resp_rd_o;
    logic      resp_xcpt_ma_o;
    logic      resp_xcpt_pf_o;
    logic      io_space_o;
    pmu_cnt_t  pmu_loads_o;
    pmu_cnt_t  pmu_stores_o;
    pmu_cnt_t  pmu_amos_o;

    // Reference model --------------------
    bus64_t ref_mem [MEM_WORDS];
    exp_t   exp_q [$];                                   // Responses in acceptance order
    int     cyc      = 0;
    int     hold_cyc = -1;                               // Cycle where ready must be low
    int     errors   = 0;
    int     n_loads  = 0;
    int     n_stores = 0;
    int     n_amos   = 0;
    instr_t op_list [20] = '{LB, LBU, LH, LHU, LW, LWU, LD, SB, SH, SW, SD,
                             AMO_SWAPD, AMO_ADDD, AMO_XORD, AMO_ANDD, AMO_ORD,
                             AMO_MIND, AMO_MAXD, AMO_MINDU, AMO_MAXDU};

    mem_unit_top DUT (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;
    always @(posedge clk_i) cyc <= cyc + 1;

    function automatic int size_bytes(instr_t op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;                       // LD, SD and all AMOs
        endcase
    endfunction

    // 0 load, 1 store, 2 AMO
    function automatic int op_kind(instr_t op);
        case (op)
            SB, SH, SW, SD: return 1;
            AMO_SWAPD, AMO_ADDD, AMO_XORD, AMO_ANDD, AMO_ORD,
            AMO_MIND, AMO_MAXD, AMO_MINDU, AMO_MAXDU: return 2;
            default: return 0;
        endcase
    endfunction

    function automatic bus64_t amo_result(instr_t op, bus64_t old, bus64_t src);
        case (op)
            AMO_ADDD:  return old + src;
            AMO_XORD:  return old ^ src;
            AMO_ANDD:  return old & src;
            AMO_ORD:   return old | src;
            AMO_MIND:  return ($signed(old) < $signed(src)) ? old : src;
            AMO_MAXD:  return ($signed(old) > $signed(src)) ? old : src;
            AMO_MINDU: return (old < src) ? old : src;
            AMO_MAXDU: return (old > src) ? old : src;
            default:   return src;                       // Swap
        endcase
    endfunction

    task automatic report_mismatch(input string name, input bus64_t got, input bus64_t exp);
        errors++;
        $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    endtask

    // Drive one request from a rising edge, return on the edge that takes it
    task automatic issue(input instr_t op, input addr_t addr, input bus64_t src,
                         input reg_addr_t rd, input bit kill);
        bus64_t imm;
        addr_t  io_base;
        exp_t   e;
        int     nb;
        int     kind;
        int     idx;
        int     off;
        bit     io_exp;
        nb   = size_bytes(op);
        kind = op_kind(op);
        if (kind == 2) imm = {$urandom, $urandom};     // Ignored by AMOs
        else imm = bus64_t'(longint'(int'($urandom_range(4095)) - 2048));
        io_base = ($urandom_range(1) == 1) ? IO_TOP_ADDR - addr_t'($urandom_range(4096))
                                           : {8'($urandom), $urandom};
        req_valid_i    <= 1'b1;
        req_instr_i    <= op;
        req_rs1_i      <= (kind == 2) ? bus64_t'(addr) : bus64_t'(addr) - imm;
        req_imm_i      <= imm;
        req_rs2_i      <= src;
        req_rd_i       <= rd;
        req_kill_i     <= kill;
        io_base_addr_i <= io_base;
        @(negedge clk_i);
        while (!req_ready_o) @(negedge clk_i);        // Hold while the cache is busy
        io_exp = (addr >= io_base) && (addr < IO_TOP_ADDR);
        assert (io_space_o == io_exp)
            else report_mismatch("io_space_o", bus64_t'(io_space_o), bus64_t'(io_exp));
        if (!kill) begin
            e.rd   = rd;
            e.data = '0;
            e.ma   = (addr[2:0] & 3'(nb - 1)) != 3'b000;
            e.pf   = !e.ma && ((addr < MEM_BASE_ADDR) || (addr >= MEM_BASE_ADDR + MEM_WORDS * 8));
            e.cyc  = cyc + 1;
            idx    = int'((addr - MEM_BASE_ADDR) >> 3);
            off    = int'(addr[2:0]);
            if (kind == 0) n_loads++;
            else if (kind == 1) n_stores++;
            else n_amos++;
            if (!e.ma && !e.pf) begin
                if (kind == 0) begin
                    for (int b = 0; b < nb; b++) e.data[b*8 +: 8] = ref_mem[idx][(off + b)*8 +: 8];
                    if ((nb < 8) && (op != LBU) && (op != LHU) && (op != LWU) && e.data[nb*8 - 1])
                        for (int b = nb; b < 8; b++) e.data[b*8 +: 8] = 8'hff;
                end else if (kind == 1) begin
                    for (int b = 0; b < nb; b++) ref_mem[idx][(off + b)*8 +: 8] = src[b*8 +: 8];
                end else begin
                    e.data       = ref_mem[idx];        // Old value comes back
                    ref_mem[idx] = amo_result(op, ref_mem[idx], src);
                    e.cyc        = cyc + AMO_LAT;
                    hold_cyc     = cyc + 1;
                end
            end
            exp_q.push_back(e);
        end
        @(posedge clk_i);
    endtask

    // Response checker --------------------
    always @(negedge clk_i) begin
        exp_t e;
        if (!reset_i && resp_valid_o) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Response at %0t ns without an accepted request", $time);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                assert (cyc == e.cyc)
                    else report_mismatch("resp_valid_o cycle", bus64_t'(cyc), bus64_t'(e.cyc));
                assert (resp_data_o == e.data) else report_mismatch("resp_data_o", resp_data_o, e.data);
                assert (resp_rd_o == e.rd)
                    else report_mismatch("resp_rd_o", bus64_t'(resp_rd_o), bus64_t'(e.rd));
                assert (resp_xcpt_ma_o == e.ma)
                    else report_mismatch("resp_xcpt_ma_o", bus64_t'(resp_xcpt_ma_o), bus64_t'(e.ma));
                assert (resp_xcpt_pf_o == e.pf)
                    else report_mismatch("resp_xcpt_pf_o", bus64_t'(resp_xcpt_pf_o), bus64_t'(e.pf));
            end
        end
        if (cyc == hold_cyc) begin                      // AMO write cycle
            assert (req_ready_o == 1'b0) else report_mismatch("req_ready_o", 64'd1, 64'd0);
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the request stream did not complete", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

    // Stimulus --------------------
    initial begin
        instr_t op;
        addr_t  addr;
        int     r;
        int     gap;
        void'($urandom(SEED));
        reset_i        = 1'b1;
        req_valid_i    = 1'b0;
        req_instr_i    = NOP;
        req_rs1_i      = '0;
        req_imm_i      = '0;
        req_rs2_i      = '0;
        req_rd_i       = '0;
        req_kill_i     = 1'b0;
        io_base_addr_i = '0;
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
        // Fill pattern from the full address, written through the DUT
        for (int w = 0; w < MEM_WORDS; w++) begin
            addr = MEM_BASE_ADDR + addr_t'(w * 8);
            issue(SD, addr, bus64_t'(addr) * 64'h9e37_79b9_7f4a_7c15, 5'(w), 1'b0);
        end
        for (int t = 0; t < N_TXN; t++) begin
            op = op_list[$urandom_range(19)];
            r  = $urandom_range(99);
            if (r < 4) addr = MEM_BASE_ADDR - addr_t'($urandom_range(512));     // I/O side
            else if (r < 8) addr = MEM_END_ADDR + addr_t'($urandom_range(512));
            else addr = MEM_BASE_ADDR + addr_t'($urandom_range(MEM_WORDS * 8 - 1));
            if ($urandom_range(9) != 0) addr[2:0] = addr[2:0] & ~3'(size_bytes(op) - 1);
            issue(op, addr, {$urandom, $urandom}, 5'($urandom), $urandom_range(19) == 0);
            gap = $urandom_range(MAX_GAP);
            if (gap > 0) begin
                req_valid_i <= 1'b0;
                repeat (gap) @(posedge clk_i);
            end
        end
        req_valid_i <= 1'b0;
        while (exp_q.size() != 0) @(negedge clk_i);
        repeat (3) @(negedge clk_i);                   // Catch stray responses
        assert (pmu_loads_o == pmu_cnt_t'(n_loads))
            else report_mismatch("pmu_loads_o", bus64_t'(pmu_loads_o), bus64_t'(n_loads));
        assert (pmu_stores_o == pmu_cnt_t'(n_stores))
            else report_mismatch("pmu_stores_o", bus64_t'(pmu_stores_o), bus64_t'(n_stores));
        assert (pmu_amos_o == pmu_cnt_t'(n_amos))
            else report_mismatch("pmu_amos_o", bus64_t'(pmu_amos_o), bus64_t'(n_amos));
        $display("Run complete: %0d requests, %0d errors", MEM_WORDS + N_TXN, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: mem_unit.f
mem_unit_pkg.sv
dcache_bus_if.sv
dcache_interface.sv
dcache_ram.sv
pmu_counters.sv
mem_unit_top.sv
mem_unit_sva.sv
tb_mem_unit.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_unit \
    -f mem_unit.f -o sim_mem_unit > build.log 2>&1 \
    && ./obj_dir/sim_mem_unit > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -qx "Test passed" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
